// File: hdl/axi_pkg.sv
`default_nettype none

package axi_pkg;

	// bus field widths
	localparam int addr_bits = 32;
	localparam int data_bits = 64;
	// one write enable per data byte
	localparam int strb_bits = data_bits / 8;
	localparam int resp_bits = 2;

	// vector types for the bus fields
	typedef logic [addr_bits-1:0] addr_w;
	typedef logic [data_bits-1:0] data_w;
	typedef logic [strb_bits-1:0] strb_w;
	typedef logic [resp_bits-1:0] resp_w;

	// response codes
	localparam resp_w resp_okay = 2'b00;
	// address outside the memory window
	localparam resp_w resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// first byte address of the data memory
	localparam axi_pkg::addr_w mem_base = 32'h8000_0000;
	// depth in 64-bit words
	localparam int mem_words = 256;

	// word index is byte address bits 10..3
	localparam int idx_lo = 3;
	localparam int idx_hi = 10;

	// word index type
	typedef logic [idx_hi-idx_lo:0] idx_w;

	// operation handed from decode to execute
	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write
	} mem_op_e;

endpackage

`default_nettype wire

// File: hdl/axi_req_decode.sv
`default_nettype none

module axi_req_decode (
	input logic clk,
	input logic rst,
	input logic idle,
	input logic arvalid,
	input axi_pkg::addr_w araddr,
	output logic arready,
	input logic awvalid,
	input axi_pkg::addr_w awaddr,
	output logic awready,
	input logic wvalid,
	input axi_pkg::data_w wdata,
	input axi_pkg::strb_w wstrb,
	output logic wready,
	output mem_pkg::mem_op_e op,
	output mem_pkg::idx_w op_idx,
	output axi_pkg::data_w op_data,
	output axi_pkg::strb_w op_strb,
	output logic op_ok
);
	import axi_pkg::*;
	import mem_pkg::*;

	// first byte address past the memory window
	localparam addr_w mem_end = mem_base + addr_w'(8 * mem_words);

	// write halves, captured independently
	logic aw_full;
	logic w_full;
	addr_w aw_addr_q;
	data_w w_data_q;
	strb_w w_strb_q;

	// issue control
	logic busy;
	logic last_wr;
	logic open_slot;
	logic write_first;
	logic ar_fire;
	logic aw_fire;
	logic w_fire;
	logic wr_pair;
	logic issue_rd;
	logic issue_wr;

	// selected request
	addr_w wr_addr;
	data_w wr_data;
	strb_w wr_strb;
	addr_w sel_addr;
	logic in_range;

	// new work only when the back end is empty
	assign open_slot = idle & ~busy;
	// write pair offered together with AR and writes are due
	assign write_first = awvalid & wvalid & ~last_wr;

	assign arready = open_slot & ~aw_full & ~w_full & ~write_first;
	assign awready = open_slot & ~aw_full;
	assign wready = open_slot & ~w_full;

	assign ar_fire = arvalid & arready;
	assign aw_fire = awvalid & awready;
	assign w_fire = wvalid & wready;

	// both halves present, either held or arriving now
	assign wr_pair = (aw_full | aw_fire) & (w_full | w_fire);
	assign issue_rd = ar_fire;
	// a read accepted this cycle leaves the write halves parked
	assign issue_wr = open_slot & wr_pair & ~ar_fire;

	// held half wins over the bus half
	assign wr_addr = aw_full ? aw_addr_q : awaddr;
	assign wr_data = w_full ? w_data_q : wdata;
	assign wr_strb = w_full ? w_strb_q : wstrb;

	assign sel_addr = issue_rd ? araddr : wr_addr;
	// window check, low three bits ignored
	assign in_range = (sel_addr >= mem_base) && (sel_addr < mem_end);

	// full flags
	always_ff @(posedge clk) begin
		if (rst) begin
			aw_full <= 1'b0;
			w_full <= 1'b0;
		end else begin
			if (issue_wr)
				aw_full <= 1'b0;
			else if (aw_fire)
				aw_full <= 1'b1;
			if (issue_wr)
				w_full <= 1'b0;
			else if (w_fire)
				w_full <= 1'b1;
		end
	end

	// holding registers
	always_ff @(posedge clk) begin
		if (aw_fire)
			aw_addr_q <= awaddr;
		if (w_fire) begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
	end

	// one-cycle op, busy and fairness bit
	always_ff @(posedge clk) begin
		if (rst) begin
			op <= op_none;
			busy <= 1'b0;
			// pretend a write went last so reads lead
			last_wr <= 1'b1;
		end else begin
			op <= op_none;
			if (issue_rd) begin
				op <= op_read;
				busy <= 1'b1;
				last_wr <= 1'b0;
			end else if (issue_wr) begin
				op <= op_write;
				busy <= 1'b1;
				last_wr <= 1'b1;
			end else if (!idle) begin
				// result stage has taken over
				busy <= 1'b0;
			end
		end
	end

	// op payload, only meaningful with op
	always_ff @(posedge clk) begin
		op_idx <= sel_addr[idx_hi:idx_lo];
		op_data <= wr_data;
		op_strb <= wr_strb;
		op_ok <= in_range;
	end

endmodule

`default_nettype wire

// File: hdl/mem_execute.sv
`default_nettype none

module mem_execute (
	input logic clk,
	input logic rst,
	input mem_pkg::mem_op_e op,
	input mem_pkg::idx_w op_idx,
	input axi_pkg::data_w op_data,
	input axi_pkg::strb_w op_strb,
	input logic op_ok,
	output mem_pkg::mem_op_e res_op,
	output axi_pkg::data_w res_data,
	output logic res_ok
);
	import axi_pkg::*;
	import mem_pkg::*;

	// word array
	data_w mem [0:mem_words-1];

	// array starts cleared, same as the bus model expects
	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = '0;
		end
	end

	// byte lane write, skipped when out of range
	always_ff @(posedge clk) begin
		if (op == op_write && op_ok) begin
			for (int b = 0; b < strb_bits; b++) begin
				if (op_strb[b])
					mem[op_idx][8*b +: 8] <= op_data[8*b +: 8];
			end
		end
	end

	// registered read, zero for anything but a good read
	always_ff @(posedge clk) begin
		if (op == op_read && op_ok)
			res_data <= mem[op_idx];
		else
			res_data <= '0;
		res_ok <= op_ok;
	end

	// op follows its data by one stage
	always_ff @(posedge clk) begin
		if (rst)
			res_op <= op_none;
		else
			res_op <= op;
	end

endmodule

`default_nettype wire

// File: hdl/axi_resp_result.sv
`default_nettype none

module axi_resp_result (
	input logic clk,
	input logic rst,
	input mem_pkg::mem_op_e op,
	input mem_pkg::mem_op_e res_op,
	input axi_pkg::data_w res_data,
	input logic res_ok,
	output logic rvalid,
	output axi_pkg::data_w rdata,
	output axi_pkg::resp_w rresp,
	input logic rready,
	output logic bvalid,
	output axi_pkg::resp_w bresp,
	input logic bready,
	output logic idle
);
	import axi_pkg::*;
	import mem_pkg::*;

	typedef enum logic [1:0] {
		resp_idle,
		resp_wait,
		resp_hold
	} resp_state_e;

	resp_state_e state;
	resp_state_e state_next;
	resp_w res_code;
	logic load_rd;
	logic load_wr;
	logic resp_done;

	// SLVERR for an address outside the window
	assign res_code = res_ok ? resp_okay : resp_slverr;
	assign load_rd = (state == resp_wait) && (res_op == op_read);
	assign load_wr = (state == resp_wait) && (res_op == op_write);
	// only one of the two valids is ever up
	assign resp_done = (rvalid && rready) || (bvalid && bready);

	always_comb begin
		state_next = state;
		case (state)
			resp_idle: begin
				// decode just issued
				if (op != op_none)
					state_next = resp_wait;
			end
			resp_wait: begin
				if (res_op != op_none)
					state_next = resp_hold;
			end
			resp_hold: begin
				if (resp_done)
					state_next = resp_idle;
			end
			default: state_next = resp_idle;
		endcase
	end

	// state, idle flag and valids
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= resp_idle;
			idle <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			state <= state_next;
			// low one cycle out of reset, high again after the response transfer
			idle <= (state_next == resp_idle);
			if (load_rd)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (load_wr)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// response payload, stable while valid is held
	always_ff @(posedge clk) begin
		if (load_rd) begin
			rdata <= res_data;
			rresp <= res_code;
		end
		if (load_wr)
			bresp <= res_code;
	end

endmodule

`default_nettype wire

// File: hdl/sram_top.sv
`default_nettype none

module sram_top (
	input logic clk,
	input logic rst,
	// read address
	input logic arvalid,
	input axi_pkg::addr_w araddr,
	output logic arready,
	// read data
	output logic rvalid,
	output axi_pkg::data_w rdata,
	output axi_pkg::resp_w rresp,
	input logic rready,
	// write address
	input logic awvalid,
	input axi_pkg::addr_w awaddr,
	output logic awready,
	// write data
	input logic wvalid,
	input axi_pkg::data_w wdata,
	input axi_pkg::strb_w wstrb,
	output logic wready,
	// write response
	output logic bvalid,
	output axi_pkg::resp_w bresp,
	input logic bready
);
	import axi_pkg::*;
	import mem_pkg::*;

	// decode to execute
	mem_op_e op;
	idx_w op_idx;
	data_w op_data;
	strb_w op_strb;
	logic op_ok;

	// execute to result
	mem_op_e res_op;
	data_w res_data;
	logic res_ok;

	// result back to decode
	logic idle;

	axi_req_decode u_decode (
		.clk(clk),
		.rst(rst),
		.idle(idle),
		.arvalid(arvalid),
		.araddr(araddr),
		.arready(arready),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.awready(awready),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.wready(wready),
		.op(op),
		.op_idx(op_idx),
		.op_data(op_data),
		.op_strb(op_strb),
		.op_ok(op_ok)
	);

	mem_execute u_execute (
		.clk(clk),
		.rst(rst),
		.op(op),
		.op_idx(op_idx),
		.op_data(op_data),
		.op_strb(op_strb),
		.op_ok(op_ok),
		.res_op(res_op),
		.res_data(res_data),
		.res_ok(res_ok)
	);

	axi_resp_result u_result (
		.clk(clk),
		.rst(rst),
		.op(op),
		.res_op(res_op),
		.res_data(res_data),
		.res_ok(res_ok),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.idle(idle)
	);

endmodule

`default_nettype wire

// File: tb/sram_properties.sv
`default_nettype none

module sram_properties (
	input logic clk,
	input logic rst,
	input logic arready,
	input logic awready,
	input logic wready,
	input logic rvalid,
	input axi_pkg::data_w rdata,
	input axi_pkg::resp_w rresp,
	input logic rready,
	input logic bvalid,
	input axi_pkg::resp_w bresp,
	input logic bready
);

	// one response channel at a time
	resp_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(rvalid && bvalid))
		else $error("rvalid and bvalid high together");

	// read response held until rready
	read_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response dropped or changed before rready");

	// write response held until bready
	write_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	// request side closed while a response waits
	ready_closed: assert property (@(posedge clk) disable iff (rst)
		(rvalid || bvalid) |-> !(arready || awready || wready))
		else $error("request ready high while a response is pending");

endmodule

`default_nettype wire

// File: tb/sram_tb.sv
`default_nettype none

module sram_tb;
	import axi_pkg::*;
	import mem_pkg::*;

	localparam int clk_period = 40;
	localparam int n_txn = 400;
	// generous cycle budget per transaction
	localparam int txn_cycles = 40;

	logic clk;
	logic rst;
	logic arvalid;
	addr_w araddr;
	logic arready;
	logic rvalid;
	data_w rdata;
	resp_w rresp;
	logic rready;
	logic awvalid;
	addr_w awaddr;
	logic awready;
	logic wvalid;
	data_w wdata;
	strb_w wstrb;
	logic wready;
	logic bvalid;
	resp_w bresp;
	logic bready;

	// reference memory
	data_w model [0:mem_words-1];
	// last kind served, reads lead after reset
	logic last_wr_model;
	int seed;

	sram_top dut (
		.clk(clk),
		.rst(rst),
		.arvalid(arvalid),
		.araddr(araddr),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.awready(awready),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready)
	);

	bind sram_top sram_properties u_props (
		.clk(clk),
		.rst(rst),
		.arready(arready),
		.awready(awready),
		.wready(wready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// watchdog
	initial begin
		#(n_txn * txn_cycles * clk_period);
		$display("timeout: the transactions did not complete within %0d time units",
			n_txn * txn_cycles * clk_period);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check_val(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERROR at time %0t: %s expected %0h actual %0h",
				$time, name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// memory window, low three bits don't matter
	function automatic logic in_range(input addr_w a);
		addr_w offset;
		offset = a - mem_base;
		return (a >= mem_base) && ((offset >> 3) < addr_w'(mem_words));
	endfunction

	// about one in eight outside the window, half the hits on a small hot set
	task automatic pick_addr(output addr_w a);
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] == 3'd0)
			a = r[3] ? mem_base + 32'h800 + {20'd0, r[15:4]} : {1'b0, r[31:1]};
		else
			a = mem_base + {21'd0, r[15:8] & (r[16] ? 8'hff : 8'h0f), r[6:4]};
	endtask

	// one read, one write, or both offered together
	task automatic run_txn(input logic do_rd, input logic do_wr, input addr_w ra,
		input addr_w wa, input data_w wd, input strb_w ws, input int aw_dly,
		input int w_dly);
		int cyc;
		int ar_edge;
		int aw_edge;
		int w_edge;
		logic dual;
		logic rd_first;
		logic ar_sent;
		logic aw_sent;
		logic w_sent;
		logic rd_seen;
		logic wr_seen;
		logic rd_done;
		logic wr_done;
		data_w exp_data;
		resp_w exp_resp;
		data_w held_rdata;
		resp_w held_rresp;
		resp_w held_bresp;
		idx_w idx;

		dual = do_rd & do_wr;
		// kind not served last goes first
		rd_first = last_wr_model;
		ar_sent = !do_rd;
		aw_sent = !do_wr;
		w_sent = !do_wr;
		rd_seen = 1'b0;
		wr_seen = 1'b0;
		rd_done = !do_rd;
		wr_done = !do_wr;
		cyc = 0;
		ar_edge = 0;
		aw_edge = 0;
		w_edge = 0;
		held_rdata = '0;
		held_rresp = '0;
		held_bresp = '0;
		while (!(rd_done && wr_done)) begin
			@(posedge clk);
			cyc++;
			arvalid <= !ar_sent;
			awvalid <= !aw_sent && (cyc > aw_dly);
			wvalid <= !w_sent && (cyc > w_dly);
			araddr <= ra;
			awaddr <= wa;
			wdata <= wd;
			wstrb <= ws;
			rready <= 1'($random(seed));
			bready <= 1'($random(seed));
			@(negedge clk);
			// full request inside the DUT, nothing more may be taken
			if (rvalid || bvalid || (ar_sent && aw_sent && w_sent))
				check_val("arready/awready/wready", 64'd0, 64'({arready, awready, wready}));
			check_val("rvalid&bvalid", 64'd0, 64'(rvalid & bvalid));
			// transfers land on the coming edge
			if (arvalid && arready) begin
				ar_sent = 1'b1;
				ar_edge = cyc + 1;
			end
			if (awvalid && awready) begin
				aw_sent = 1'b1;
				aw_edge = cyc + 1;
			end
			if (wvalid && wready) begin
				w_sent = 1'b1;
				w_edge = cyc + 1;
			end
			if (rvalid) begin
				check_val("rvalid unexpected", 64'd0, 64'(rd_done));
				if (!rd_seen) begin
					rd_seen = 1'b1;
					if (dual && !wr_seen)
						check_val("read served first", 64'(rd_first), 64'd1);
					check_val("rvalid latency", 64'd2, 64'(cyc - ar_edge));
					idx = ra[idx_hi:idx_lo];
					exp_data = in_range(ra) ? model[idx] : '0;
					exp_resp = in_range(ra) ? resp_okay : resp_slverr;
					check_val("rdata", exp_data, rdata);
					check_val("rresp", 64'(exp_resp), 64'(rresp));
					held_rdata = rdata;
					held_rresp = rresp;
					last_wr_model = 1'b0;
				end
				check_val("rdata held", held_rdata, rdata);
				check_val("rresp held", 64'(held_rresp), 64'(rresp));
				if (rready)
					rd_done = 1'b1;
			end
			if (bvalid) begin
				check_val("bvalid unexpected", 64'd0, 64'(wr_done));
				if (!wr_seen) begin
					wr_seen = 1'b1;
					if (dual && !rd_seen)
						check_val("read served first", 64'(rd_first), 64'd0);
					// halves parked behind a read issue later
					if (!(dual && rd_first))
						check_val("bvalid latency", 64'd2,
							64'(cyc - ((aw_edge > w_edge) ? aw_edge : w_edge)));
					if (in_range(wa)) begin
						idx = wa[idx_hi:idx_lo];
						for (int b = 0; b < strb_bits; b++) begin
							if (ws[b])
								model[idx][8*b +: 8] = wd[8*b +: 8];
						end
					end
					exp_resp = in_range(wa) ? resp_okay : resp_slverr;
					check_val("bresp", 64'(exp_resp), 64'(bresp));
					held_bresp = bresp;
					last_wr_model = 1'b1;
				end
				check_val("bresp held", 64'(held_bresp), 64'(bresp));
				if (bready)
					wr_done = 1'b1;
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		addr_w ra;
		addr_w wa;
		data_w wd;
		strb_w ws;

		seed = 32'he544_c72a;
		last_wr_model = 1'b1;
		rst = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		rready = 1'b0;
		bready = 1'b0;
		for (int i = 0; i < mem_words; i++)
			model[i] = '0;

		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		// first cycle out of reset, nothing ready yet
		check_val("arready/awready/wready", 64'd0, 64'({arready, awready, wready}));
		repeat (4) begin
			check_val("rvalid", 64'd0, 64'(rvalid));
			check_val("bvalid", 64'd0, 64'(bvalid));
			@(negedge clk);
		end

		for (int n = 0; n < n_txn; n++) begin
			r = $random(seed);
			pick_addr(ra);
			pick_addr(wa);
			wd = {$random(seed), $random(seed)};
			ws = strb_w'($random(seed));
			case (r[1:0])
				2'd0: run_txn(1'b1, 1'b0, ra, wa, wd, ws, 0, 0);
				// read and write pair offered in the same cycle
				2'd3: run_txn(1'b1, 1'b1, ra, wa, wd, ws, 0, 0);
				default: run_txn(1'b0, 1'b1, ra, wa, wd, ws, int'(r[3:2]), int'(r[5:4]));
			endcase
		end

		@(posedge clk);
		arvalid <= 1'b0;
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (2) @(posedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hdl/axi_pkg.sv
hdl/mem_pkg.sv
hdl/axi_req_decode.sv
hdl/mem_execute.sv
hdl/axi_resp_result.sv
hdl/sram_top.sv
tb/sram_properties.sv
tb/sram_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sram testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module sram_tb \
	-f verilog.f \
	-o sram_sim

# pass or fail is read from the log
./obj_dir/sram_sim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi
